/* dc_control_pkg.sv */
package dc_control_pkg;

    ////////////////////////////////////////////////////////////
    // reset hold timing
    ////////////////////////////////////////////////////////////

    // width of the hold counter in the reset generators
    localparam int hold_count_width = 32;

    // about one second of control clock cycles
    localparam logic [hold_count_width-1:0] reset_hold_cycles_default = 32'd32_000_000;

    ////////////////////////////////////////////////////////////
    // glow and blink periods
    ////////////////////////////////////////////////////////////

    // breathing period is 2**(bit+1) cycles
    localparam int slow_glow_bit_default = 26;
    localparam int fast_glow_bit_default = 22;

    // blink gate while forced generation is active
    localparam int blink_bit_default = 24;

    // brightness steps in the glow ramp
    localparam int glow_depth = 4;

    ////////////////////////////////////////////////////////////
    // status led modes
    ////////////////////////////////////////////////////////////

    localparam int led_mode_width = 2;

    localparam logic [led_mode_width-1:0] led_mode_status    = 2'd0;
    localparam logic [led_mode_width-1:0] led_mode_opt_reset = 2'd1;
    localparam logic [led_mode_width-1:0] led_mode_dc_reset  = 2'd2;
    // value 3 is treated like led_mode_opt_reset

endpackage

/* status_sync.sv */
`timescale 1ns/1ns

module status_sync (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic pll54_locked,
    input  logic pll_hdmi_locked,
    input  logic resync,
    input  logic force_generate,
    input  logic adv7513_ready,
    input  logic output_fullcycle,
    output logic hdmi_ready,
    output logic resync_sync,
    output logic force_generate_sync,
    output logic adv_ready_sync,
    output logic pll_reset_request,
    output logic output_ready
);

    // all six levels come from other clock domains
    logic [5:0] async_level;
    logic [5:0] meta_stage;
    logic [5:0] sync_stage;

    logic pll54_sync;
    logic fullcycle_sync;

    // previous lock levels for falling edge detection
    logic pll54_prev;
    logic hdmi_prev;

    assign async_level = {output_fullcycle, adv7513_ready, force_generate,
                          resync, pll_hdmi_locked, pll54_locked};

    ////////////////////////////////////////////////////////////
    // two flop synchronizer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            meta_stage <= '0;
            sync_stage <= '0;
        end else begin
            meta_stage <= async_level;
            sync_stage <= meta_stage;
        end
    end

    assign pll54_sync          = sync_stage[0];
    assign hdmi_ready          = sync_stage[1];
    assign resync_sync         = sync_stage[2];
    assign force_generate_sync = sync_stage[3];
    assign adv_ready_sync      = sync_stage[4];
    assign fullcycle_sync      = sync_stage[5];

    ////////////////////////////////////////////////////////////
    // lock loss and output gate
    ////////////////////////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pll54_prev        <= 1'b0;
            hdmi_prev         <= 1'b0;
            pll_reset_request <= 1'b0;
            output_ready      <= 1'b0;
        end else begin
            pll54_prev <= pll54_sync;
            hdmi_prev  <= hdmi_ready;
            // one pulse even when both locks drop together
            pll_reset_request <= (pll54_prev & ~pll54_sync) |
                                 (hdmi_prev & ~hdmi_ready);
            // transmitter setup may run once the output is stable
            output_ready <= hdmi_ready & fullcycle_sync;
        end
    end

endmodule

/* reset_hold_generator.sv */
`timescale 1ns/1ns

module reset_hold_generator #(
    parameter logic [dc_control_pkg::hold_count_width-1:0] hold_cycles =
        dc_control_pkg::reset_hold_cycles_default
) (
    input  logic control_clock,
    input  logic request,
    output logic nreset
);

    logic [$bits(hold_cycles)-1:0] hold_count;

    // request clears the count and holds nreset low
    always_ff @(posedge control_clock) begin
        if (request) begin
            hold_count <= '0;
            nreset     <= 1'b0;
        end else if (!nreset) begin
            if (hold_count == hold_cycles) begin
                // release, counter stays where it is
                nreset <= 1'b1;
            end else begin
                hold_count <= hold_count + 1'b1;
            end
        end
    end

endmodule

/* led_glow.sv */
`timescale 1ns/1ns

module led_glow #(
    parameter int glow_bit = dc_control_pkg::slow_glow_bit_default
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow
);

    import dc_control_pkg::*;

    logic [glow_bit:0]     glow_count;
    logic [glow_depth-1:0] ramp;
    logic [glow_depth-1:0] pwm_phase;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_count <= '0;
        end else begin
            glow_count <= glow_count + 1'b1;
        end
    end

    // brightness from the bits under the top bit
    // top bit set means the ramp runs back down
    always_comb begin
        ramp = glow_count[glow_bit-1 -: glow_depth];
        if (glow_count[glow_bit]) begin
            ramp = ~ramp;
        end
    end

    // fast pwm phase against the slow ramp
    assign pwm_phase = glow_count[glow_depth-1:0];
    assign glow      = (pwm_phase < ramp);

endmodule

/* status_led_driver.sv */
`timescale 1ns/1ns

module status_led_driver #(
    parameter int blink_bit = dc_control_pkg::blink_bit_default
) (
    input  logic                                    control_clock,
    input  logic                                    reset_dc,
    input  logic [dc_control_pkg::led_mode_width-1:0] led_mode,
    input  logic                                    dc_nreset,
    input  logic                                    opt_nreset,
    input  logic                                    hdmi_ready,
    input  logic                                    resync_sync,
    input  logic                                    force_generate_sync,
    input  logic                                    adv_ready_sync,
    input  logic                                    slow_glow,
    input  logic                                    fast_glow,
    output logic                                    status_led
);

    import dc_control_pkg::*;

    logic [blink_bit:0] blink_count;
    logic               blink_on;
    logic               status_level;
    logic               led_next;

    ////////////////////////////////////////////////////////////
    // blink timebase
    ////////////////////////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count <= '0;
        end else begin
            blink_count <= blink_count + 1'b1;
        end
    end

    assign blink_on = blink_count[blink_bit];

    ////////////////////////////////////////////////////////////
    // led level selection, low means lit
    ////////////////////////////////////////////////////////////

    // system state in status mode, first match wins
    always_comb begin
        if (!hdmi_ready) begin
            // no hdmi clock, led dark
            status_level = 1'b1;
        end else if (resync_sync) begin
            status_level = ~fast_glow;
        end else if (force_generate_sync) begin
            status_level = blink_on ? ~fast_glow : 1'b1;
        end else if (adv_ready_sync) begin
            status_level = 1'b0;
        end else begin
            // waiting for the transmitter
            status_level = ~slow_glow;
        end
    end

    always_comb begin
        case (led_mode)
            led_mode_status:    led_next = status_level;
            led_mode_dc_reset:  led_next = dc_nreset;
            led_mode_opt_reset: led_next = opt_nreset;
            // mode 3 shows the option reset too
            default:            led_next = opt_nreset;
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            status_led <= 1'b1;
        end else begin
            status_led <= led_next;
        end
    end

endmodule

/* dc_reset_control.sv */
`timescale 1ns/1ns

module dc_reset_control #(
    parameter logic [dc_control_pkg::hold_count_width-1:0] hold_cycles =
        dc_control_pkg::reset_hold_cycles_default,
    parameter int slow_glow_bit = dc_control_pkg::slow_glow_bit_default,
    parameter int fast_glow_bit = dc_control_pkg::fast_glow_bit_default,
    parameter int blink_bit     = dc_control_pkg::blink_bit_default
) (
    input  logic                                    control_clock,
    // console reset request and block reset in one
    input  logic                                    reset_dc,
    input  logic                                    reset_opt,
    input  logic [dc_control_pkg::led_mode_width-1:0] led_mode,
    // levels from other clock domains
    input  logic                                    pll54_locked,
    input  logic                                    pll_hdmi_locked,
    input  logic                                    resync,
    input  logic                                    force_generate,
    input  logic                                    adv7513_ready,
    input  logic                                    output_fullcycle,
    output logic                                    dc_nreset,
    output logic                                    opt_nreset,
    output logic                                    pll_reset_request,
    output logic                                    hdmi_ready,
    output logic                                    output_ready,
    output logic                                    status_led
);

    logic resync_sync;
    logic force_generate_sync;
    logic adv_ready_sync;
    logic slow_glow;
    logic fast_glow;

    ////////////////////////////////////////////////////////////
    // status inputs into control_clock
    ////////////////////////////////////////////////////////////

    status_sync i_status_sync (
        .control_clock       (control_clock),
        .reset_dc            (reset_dc),
        .pll54_locked        (pll54_locked),
        .pll_hdmi_locked     (pll_hdmi_locked),
        .resync              (resync),
        .force_generate      (force_generate),
        .adv7513_ready       (adv7513_ready),
        .output_fullcycle    (output_fullcycle),
        .hdmi_ready          (hdmi_ready),
        .resync_sync         (resync_sync),
        .force_generate_sync (force_generate_sync),
        .adv_ready_sync      (adv_ready_sync),
        .pll_reset_request   (pll_reset_request),
        .output_ready        (output_ready)
    );

    ////////////////////////////////////////////////////////////
    // console and option reset outputs
    ////////////////////////////////////////////////////////////

    reset_hold_generator #(
        .hold_cycles (hold_cycles)
    ) i_dc_reset (
        .control_clock (control_clock),
        .request       (reset_dc),
        .nreset        (dc_nreset)
    );

    reset_hold_generator #(
        .hold_cycles (hold_cycles)
    ) i_opt_reset (
        .control_clock (control_clock),
        .request       (reset_opt),
        .nreset        (opt_nreset)
    );

    ////////////////////////////////////////////////////////////
    // led patterns
    ////////////////////////////////////////////////////////////

    led_glow #(
        .glow_bit (slow_glow_bit)
    ) i_slow_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (slow_glow)
    );

    led_glow #(
        .glow_bit (fast_glow_bit)
    ) i_fast_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (fast_glow)
    );

    status_led_driver #(
        .blink_bit (blink_bit)
    ) i_status_led (
        .control_clock       (control_clock),
        .reset_dc            (reset_dc),
        .led_mode            (led_mode),
        .dc_nreset           (dc_nreset),
        .opt_nreset          (opt_nreset),
        .hdmi_ready          (hdmi_ready),
        .resync_sync         (resync_sync),
        .force_generate_sync (force_generate_sync),
        .adv_ready_sync      (adv_ready_sync),
        .slow_glow           (slow_glow),
        .fast_glow           (fast_glow),
        .status_led          (status_led)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period = 40
) (
    output logic control_clock
);

    initial begin
        control_clock = 1'b0;
    end

    // free running, first rising edge at half a period
    always begin
        #(period / 2);
        control_clock = ~control_clock;
    end

endmodule

/* tb_dc_reset_control.sv */
`timescale 1ns/1ns

module tb_dc_reset_control;

    import dc_control_pkg::*;

    localparam logic [31:0] hold_cycles = 32'd50;
    localparam int          step_delay  = 5;
    localparam int          rise_limit  = 1000;

    logic          control_clock;
    logic          reset_dc;
    logic          reset_opt;
    logic [1:0]    led_mode;
    logic          pll54_locked;
    logic          pll_hdmi_locked;
    logic          resync;
    logic          force_generate;
    logic          adv7513_ready;
    logic          output_fullcycle;
    logic          dc_nreset;
    logic          opt_nreset;
    logic          pll_reset_request;
    logic          hdmi_ready;
    logic          output_ready;
    logic          status_led;

    int            errors;
    int            timeouts;
    int            fd;
    int            code;
    logic [127:0]  cmd;
    logic [2047:0] line;
    logic [31:0]   arg [0:6];

    tb_clock_gen #(
        .period (40)
    ) i_clock_gen (
        .control_clock (control_clock)
    );

    dc_reset_control #(
        .hold_cycles   (hold_cycles),
        .slow_glow_bit (9),
        .fast_glow_bit (7),
        .blink_bit     (8)
    ) i_dut (
        .control_clock     (control_clock),
        .reset_dc          (reset_dc),
        .reset_opt         (reset_opt),
        .led_mode          (led_mode),
        .pll54_locked      (pll54_locked),
        .pll_hdmi_locked   (pll_hdmi_locked),
        .resync            (resync),
        .force_generate    (force_generate),
        .adv7513_ready     (adv7513_ready),
        .output_fullcycle  (output_fullcycle),
        .dc_nreset         (dc_nreset),
        .opt_nreset        (opt_nreset),
        .pll_reset_request (pll_reset_request),
        .hdmi_ready        (hdmi_ready),
        .output_ready      (output_ready),
        .status_led        (status_led)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // one rising edge, then on to the drive point
    task automatic step();
        @(posedge control_clock);
        #(step_delay);
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("[FAIL] %s expected %0h actual %0h at %0t", name, expected, actual, $time);
    endtask

    task automatic drive_request(input int which, input logic level);
        if (which == 0) begin
            reset_dc = level;
        end else begin
            reset_opt = level;
        end
    endtask

    task automatic pulse_request(input int which, input int cycles);
        drive_request(which, 1'b1);
        repeat (cycles) step();
        drive_request(which, 1'b0);
    endtask

    // nreset must rise on edge hold_cycles+1 after the request falls
    task automatic count_rise(input int which, input int expected);
        int  edges;
        logic done;
        edges = 0;
        done  = 1'b0;
        while (!done && edges < rise_limit) begin
            step();
            edges++;
            done = (which == 0) ? dc_nreset : opt_nreset;
        end
        if (!done) begin
            timeouts++;
            $display("timeout: reset output %0d never released", which);
        end else if (edges != expected) begin
            if (which == 0) begin
                report_value("dc_nreset edges", expected, edges);
            end else begin
                report_value("opt_nreset edges", expected, edges);
            end
        end
    endtask

    task automatic count_pulses(input int cycles, input int expected);
        int seen;
        seen = 0;
        repeat (cycles) begin
            step();
            if (pll_reset_request) begin
                seen++;
            end
        end
        if (seen != expected) begin
            report_value("pll_reset_request pulses", expected, seen);
        end
    endtask

    task automatic see_both(input int limit);
        int   n;
        logic seen_low;
        logic seen_high;
        n         = 0;
        seen_low  = 1'b0;
        seen_high = 1'b0;
        while (!(seen_low && seen_high) && n < limit) begin
            step();
            n++;
            seen_low  = seen_low | (status_led === 1'b0);
            seen_high = seen_high | (status_led === 1'b1);
        end
        if (!(seen_low && seen_high)) begin
            errors++;
            $display("status_led did not show both levels within %0d cycles", limit);
        end
    endtask

    // blink gate clear means a long dark stretch
    task automatic find_dark(input int run_len, input int limit);
        int n;
        int run;
        n   = 0;
        run = 0;
        while (run < run_len && n < limit) begin
            step();
            n++;
            run = (status_led === 1'b1) ? run + 1 : 0;
        end
        if (run < run_len) begin
            errors++;
            $display("status_led never stayed dark for %0d cycles within %0d", run_len, limit);
        end
    endtask

    task automatic check_mirror(input int which, input int cycles, input int req_cycles);
        int   i;
        logic prev;
        logic in_reset;
        for (i = 0; i < cycles; i++) begin
            drive_request(which, i < req_cycles);
            prev     = (which == 0) ? dc_nreset : opt_nreset;
            in_reset = reset_dc;
            step();
            // console reset also forces the led dark
            if (in_reset) begin
                if (status_led !== 1'b1) begin
                    report_value("status_led", 1'b1, status_led);
                end
            end else if (status_led !== prev) begin
                report_value("status_led", prev, status_led);
            end
        end
    endtask

    // hdmi_ready follows the settled hdmi lock input
    task automatic expect_levels();
        if (dc_nreset !== arg[0][0]) begin
            report_value("dc_nreset", arg[0], dc_nreset);
        end
        if (opt_nreset !== arg[1][0]) begin
            report_value("opt_nreset", arg[1], opt_nreset);
        end
        if (status_led !== arg[2][0]) begin
            report_value("status_led", arg[2], status_led);
        end
        if (output_ready !== arg[3][0]) begin
            report_value("output_ready", arg[3], output_ready);
        end
        if (hdmi_ready !== pll_hdmi_locked) begin
            report_value("hdmi_ready", pll_hdmi_locked, hdmi_ready);
        end
    endtask

    task automatic read_args(input int count);
        int i;
        int got;
        got = 0;
        for (i = 0; i < count; i++) begin
            got += $fscanf(fd, "%h", arg[i]);
        end
        if (got != count) begin
            errors++;
            $display("vector line for %0s has %0d of %0d fields", cmd, got, count);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // vector interpreter
    ////////////////////////////////////////////////////////////

    task automatic run_vectors();
        while (!$feof(fd)) begin
            cmd  = '0;
            code = $fscanf(fd, "%s", cmd);
            if (code == 1) begin
                case (cmd)
                    "#": code = $fgets(line, fd);
                    "in": begin
                        read_args(7);
                        pll54_locked     = arg[0][0];
                        pll_hdmi_locked  = arg[1][0];
                        resync           = arg[2][0];
                        force_generate   = arg[3][0];
                        adv7513_ready    = arg[4][0];
                        output_fullcycle = arg[5][0];
                        led_mode         = arg[6][1:0];
                    end
                    "pulse": begin
                        read_args(2);
                        pulse_request(arg[0], arg[1]);
                    end
                    "rise": begin
                        read_args(2);
                        count_rise(arg[0], arg[1]);
                    end
                    "wait": begin
                        read_args(1);
                        repeat (arg[0]) step();
                    end
                    "expect": begin
                        read_args(4);
                        expect_levels();
                    end
                    "pulses": begin
                        read_args(2);
                        count_pulses(arg[0], arg[1]);
                    end
                    "both": begin
                        read_args(1);
                        see_both(arg[0]);
                    end
                    "dark": begin
                        read_args(2);
                        find_dark(arg[0], arg[1]);
                    end
                    "mirror": begin
                        read_args(3);
                        check_mirror(arg[0], arg[1], arg[2]);
                    end
                    default: begin
                        errors++;
                        $display("unknown vector command %0s", cmd);
                        code = $fgets(line, fd);
                    end
                endcase
            end
        end
    endtask

    initial begin
        errors           = 0;
        timeouts         = 0;
        reset_dc         = 1'b1;
        reset_opt        = 1'b1;
        led_mode         = led_mode_status;
        pll54_locked     = 1'b0;
        pll_hdmi_locked  = 1'b0;
        resync           = 1'b0;
        force_generate   = 1'b0;
        adv7513_ready    = 1'b0;
        output_fullcycle = 1'b0;
        repeat (8) step();

        // levels while reset is held
        arg[0] = 32'h0;
        arg[1] = 32'h0;
        arg[2] = 32'h1;
        arg[3] = 32'h0;
        expect_levels();
        if (pll_reset_request !== 1'b0) begin
            report_value("pll_reset_request", 32'h0, pll_reset_request);
        end
        reset_dc = 1'b0;

        fd = $fopen("dc_reset_control_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open dc_reset_control_vectors.txt");
        end else begin
            run_vectors();
            $fclose(fd);
        end

        $display("run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* dc_reset_control_vectors.txt */
# one command per line, arguments in hex, req 0 is reset_dc and req 1 is reset_opt
# in pll54 hdmi resync force adv full mode / pulse req n / rise req edges / wait n
# expect dc_nreset opt_nreset status_led output_ready / pulses n count / both n
# dark run limit / mirror req n req_cycles
# console reset release after startup
rise 0 33
# option reset release, then restart in mid count
pulse 1 4
rise 1 33
pulse 1 3
wait 14
expect 1 0 1 0
pulse 1 2
rise 1 33
# status mode, no lock then lock with transmitter ready
in 0 0 0 0 0 0 0
wait 4
expect 1 1 1 0
in 1 1 0 0 1 0 0
wait 4
expect 1 1 0 0
# output_ready combinations
in 1 1 0 0 1 1 0
wait 4
expect 1 1 0 1
in 1 0 0 0 1 1 0
wait 4
expect 1 1 1 0
# lock loss pulses
in 1 1 0 0 1 1 0
pulses 6 0
in 0 1 0 0 1 1 0
pulses 6 1
in 1 1 0 0 1 1 0
pulses 6 0
in 1 0 0 0 1 1 0
pulses 6 1
in 1 1 0 0 1 1 0
pulses 6 0
in 0 0 0 0 1 1 0
pulses 6 1
in 1 1 0 0 1 1 0
pulses 6 0
# glow patterns, fast on resync, slow while waiting, blink on forced generation
in 1 1 1 0 0 0 0
wait 4
both 100
in 1 1 0 0 0 0 0
wait 4
both 400
in 1 1 0 1 0 0 0
wait 4
dark 100 400
# reset mirroring in dc, opt and mode 3
in 1 1 0 0 1 1 2
mirror 0 48 3
in 1 1 0 0 1 1 1
mirror 1 48 3
in 1 1 0 0 1 1 3
mirror 1 48 3
expect 1 1 1 1

/* tb.f */
dc_control_pkg.sv
status_sync.sv
reset_hold_generator.sv
led_glow.sv
status_led_driver.sv
dc_reset_control.sv
tb_clock_gen.sv
tb_dc_reset_control.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dc_reset_control
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
